//--- tb.f
mem_sched_pkg.sv
burst_dispatcher.sv
burst_slot.sv
timing_controller.sv
cmd_issuer.sv
mem_sched_top.sv
tb_mem_sched.sv

//--- Bender.yml
package:
  name: mem_sched

sources:
  - mem_sched_pkg.sv
  - burst_dispatcher.sv
  - burst_slot.sv
  - timing_controller.sv
  - cmd_issuer.sv
  - mem_sched_top.sv
  - target: simulation
    files:
      - tb_mem_sched.sv

//--- tb_mem_sched.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_sched;
	import mem_sched_pkg::*;

	localparam int no_of_bursts_tb = 4; // slots in the DUT
	localparam int burst_beats_tb  = 8; // write beats per burst
	localparam int cyc_bound    = act_to_act_same_bank + burst_time + 10; // per command
	localparam int cmd_total    = 2 + 2 + 6 + 8 + (no_of_bursts_tb + 1); // commands over all tests
	localparam int limit_cycles = (cmd_total + 6) * cyc_bound; // plus slack for reset and idle

	logic       clk;
	logic       rst_n;
	logic       req_valid;
	logic       wr_beat;
	logic       busy;
	burst_req_t req;
	dram_cmd_t  dram_cmd;

	dram_cmd_t log_cmd [$]; // every issued command
	int        log_cyc [$]; // cycle it was seen
	int        cycle = 0;
	int        errors = 0;
	int        checks = 0;
	int        tests_run = 0;
	int        test_err0;
	string     cur_test = "reset";
	dram_addr_t bank0_addr; // row opened in bank 0

	mem_sched_top #(
		.no_of_bursts (no_of_bursts_tb),
		.burst_beats  (burst_beats_tb)
	) mem_sched_top_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req       (req),
		.wr_beat   (wr_beat),
		.busy      (busy),
		.dram_cmd  (dram_cmd)
	);

	always #50 clk = ~clk; // 100 ns period

	always @(posedge clk) cycle <= cycle + 1;

	always @(negedge clk) begin // outputs settled mid-cycle
		if (dram_cmd.cmd != none) begin
			log_cmd.push_back(dram_cmd);
			log_cyc.push_back(cycle);
		end
	end

	initial begin
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: test %s hung waiting for the DUT", cur_test);
		$display("TEST FAILED");
		$finish;
	end

	task automatic check(input string sig, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, sig, got, exp);
		end
	endtask

	task automatic step();
		@(posedge clk);
		#10; // drive after the edge
	endtask

	function automatic dram_addr_t make_addr(input logic [1:0] bg, input logic [1:0] bank,
	                                         input logic [15:0] row);
		dram_addr_t a;
		a.bg   = bg;
		a.bank = bank;
		a.row  = row;
		return a;
	endfunction

	function automatic int count_cmd(input int from, input dram_cmd_e c, input dram_addr_t a);
		int n;
		n = 0;
		for (int i = from; i < log_cmd.size(); i++) begin
			if (log_cmd[i].cmd == c && log_cmd[i].addr == a) n++;
		end
		return n;
	endfunction

	task automatic send_req(input req_type_e t, input dram_addr_t a);
		step();
		req.rtype = t;
		req.addr  = a;
		req_valid = 1'b1;
		step();
		req_valid = 1'b0; // one-cycle strobe
	endtask

	task automatic send_beats(input int n);
		step();
		wr_beat = 1'b1;
		repeat (n) step(); // held across n edges
		wr_beat = 1'b0;
	endtask

	task automatic wait_cmds(input int base, input int n);
		while (log_cmd.size() < base + n) @(posedge clk);
	endtask

	task automatic settle(input int base, input int n);
		repeat (15) step(); // slots back to empty
		check("command count", log_cmd.size() - base, n);
	endtask

	task automatic begin_test(input string name);
		cur_test  = name;
		test_err0 = errors;
	endtask

	task automatic end_test();
		tests_run++;
		$display("test %s: %0d errors", cur_test, errors - test_err0);
	endtask

	task automatic test_idle();
		begin_test("idle after reset");
		repeat (10) begin
			step();
			check("dram_cmd.cmd", dram_cmd.cmd, none);
			check("busy", busy, 0);
		end
		end_test();
	endtask

	task automatic test_single_read();
		dram_addr_t a;
		int base;
		begin_test("single read");
		a = make_addr(2'd0, 2'd0, 16'($urandom()));
		base = log_cmd.size();
		send_req(read, a);
		wait_cmds(base, 2);
		check("dram_cmd.cmd", log_cmd[base].cmd, activate);
		check("dram_cmd.addr", log_cmd[base].addr, a);
		check("dram_cmd.cmd", log_cmd[base+1].cmd, read_cmd);
		check("dram_cmd.addr", log_cmd[base+1].addr, a);
		check("act to read gap ok", log_cyc[base+1] - log_cyc[base] >= act_to_col, 1);
		bank0_addr = a;
		settle(base, 2);
		end_test();
	endtask

	task automatic test_write();
		dram_addr_t a;
		int base;
		begin_test("single write");
		a = make_addr(2'd1, 2'd0, 16'($urandom()));
		base = log_cmd.size();
		send_req(write, a);
		send_beats(burst_beats_tb - 1); // slot now almost_done
		repeat (act_to_act_same_bank) step(); // time enough for an early write
		check("write_cmd before last beat", count_cmd(base, write_cmd, a), 0);
		send_beats(1);
		wait_cmds(base, 2);
		check("dram_cmd.cmd", log_cmd[base].cmd, activate);
		check("dram_cmd.addr", log_cmd[base].addr, a);
		check("dram_cmd.cmd", log_cmd[base+1].cmd, write_cmd);
		check("dram_cmd.addr", log_cmd[base+1].addr, a);
		settle(base, 2);
		end_test();
	endtask

	task automatic test_row_miss();
		dram_addr_t a1;
		dram_addr_t a2;
		int base;
		begin_test("row miss");
		a1 = bank0_addr;
		a1.row = a1.row + 16'd1 + 16'($urandom() % 100); // never the open row
		a2 = a1;
		a2.row = a1.row + 16'd1 + 16'($urandom() % 100); // misses a1 as well
		base = log_cmd.size();
		send_req(read, a1);
		wait_cmds(base, 2); // bank reopened on a1
		send_req(read, a2); // arrives while a1 row is young
		wait_cmds(base, 6);
		check("dram_cmd.cmd", log_cmd[base].cmd, precharge);
		check("dram_cmd.addr", log_cmd[base].addr, a1);
		check("dram_cmd.cmd", log_cmd[base+1].cmd, activate);
		check("dram_cmd.addr", log_cmd[base+1].addr, a1);
		check("dram_cmd.cmd", log_cmd[base+2].cmd, read_cmd);
		check("dram_cmd.addr", log_cmd[base+2].addr, a1);
		check("dram_cmd.cmd", log_cmd[base+3].cmd, precharge);
		check("dram_cmd.addr", log_cmd[base+3].addr, a2);
		check("dram_cmd.cmd", log_cmd[base+4].cmd, activate);
		check("dram_cmd.addr", log_cmd[base+4].addr, a2);
		check("dram_cmd.cmd", log_cmd[base+5].cmd, read_cmd);
		check("dram_cmd.addr", log_cmd[base+5].addr, a2);
		check("pre to act gap ok", log_cyc[base+1] - log_cyc[base] >= pre_to_act, 1);
		check("act to pre gap ok", log_cyc[base+3] - log_cyc[base+1] >= act_to_pre, 1);
		check("pre to act gap ok", log_cyc[base+4] - log_cyc[base+3] >= pre_to_act, 1);
		settle(base, 6);
		end_test();
	endtask

	task automatic test_bank_groups();
		dram_addr_t a [4];
		int base;
		int last_act;
		int last_col;
		begin_test("four bank groups");
		base = log_cmd.size();
		for (int g = 0; g < 4; g++) begin
			a[g] = make_addr(2'(g), 2'd2, 16'($urandom()));
			send_req(read, a[g]);
		end
		wait_cmds(base, 8);
		for (int g = 0; g < 4; g++) begin
			check("activate per request", count_cmd(base, activate, a[g]), 1);
			check("read_cmd per request", count_cmd(base, read_cmd, a[g]), 1);
		end
		last_act = -1000;
		last_col = -1000;
		for (int i = base; i < log_cmd.size(); i++) begin
			if (log_cmd[i].cmd == activate) begin
				check("act to act gap ok", log_cyc[i] - last_act >= act_to_act_diff_bank, 1);
				last_act = log_cyc[i];
			end else if (log_cmd[i].cmd == read_cmd) begin
				check("col to col gap ok", log_cyc[i] - last_col >= burst_time + col_to_col, 1);
				last_col = log_cyc[i];
			end
		end
		settle(base, 8);
		end_test();
	endtask

	task automatic test_busy();
		dram_addr_t a [no_of_bursts_tb];
		int base;
		begin_test("busy with full slots");
		base = log_cmd.size();
		for (int g = 0; g < no_of_bursts_tb; g++) begin
			a[g] = make_addr(2'(g), 2'd3, 16'($urandom()));
			send_req(write, a[g]);
		end
		check("busy", busy, 1); // every slot waiting for beats
		send_beats(burst_beats_tb); // go to the newest write
		while (busy) @(posedge clk);
		check("write_cmd newest slot", count_cmd(base, write_cmd, a[no_of_bursts_tb-1]), 1);
		check("write_cmd oldest slot", count_cmd(base, write_cmd, a[0]), 0);
		end_test();
	endtask

	initial begin
		clk       = 1'b0;
		rst_n     = 1'b1; // reset asserted
		req_valid = 1'b0;
		req       = '0;
		wr_beat   = 1'b0;
		void'($urandom(12798));
		repeat (4) @(posedge clk);
		#10 rst_n = 1'b0;
		test_idle();
		test_single_read();
		test_write();
		test_row_miss();
		test_bank_groups();
		test_busy();
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- mem_sched_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_sched_top #(
	parameter int no_of_bursts = 4,
	parameter int burst_beats  = 8
) (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire                            req_valid,
	input  wire mem_sched_pkg::burst_req_t req,
	input  wire                            wr_beat,
	output logic                           busy,
	output mem_sched_pkg::dram_cmd_t       dram_cmd
);
	import mem_sched_pkg::*;

	logic [no_of_bursts-1:0]         load;       // one-hot slot load
	logic [no_of_bursts-1:0]         beat;       // one-hot write beat
	logic [no_of_bursts-1:0]         col_start;  // burst under way
	burst_req_t                      load_req;
	slot_status_t [no_of_bursts-1:0] status;
	burst_state_e [no_of_bursts-1:0] slot_state;
	dram_cmd_e                       burst_cmd;
	logic [$clog2(no_of_bursts)-1:0] cmd_index;

	always_comb begin
		for (int i = 0; i < no_of_bursts; i++) begin
			slot_state[i] = status[i].state; // dispatcher only needs the state
		end
	end

	burst_dispatcher #(
		.no_of_bursts (no_of_bursts)
	) u_dispatcher (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req        (req),
		.wr_beat    (wr_beat),
		.slot_state (slot_state),
		.load       (load),
		.load_req   (load_req),
		.beat       (beat),
		.busy       (busy)
	);

	for (genvar g = 0; g < no_of_bursts; g++) begin : g_slot
		burst_slot #(
			.burst_beats (burst_beats)
		) u_slot (
			.clk       (clk),
			.rst_n     (rst_n),
			.load      (load[g]),
			.load_req  (load_req),
			.beat      (beat[g]),
			.col_start (col_start[g]),
			.status    (status[g])
		);
	end

	timing_controller #(
		.no_of_bursts (no_of_bursts)
	) u_timing (
		.clk       (clk),
		.rst_n     (rst_n),
		.status    (status),
		.burst_cmd (burst_cmd),
		.cmd_index (cmd_index)
	);

	cmd_issuer #(
		.no_of_bursts (no_of_bursts)
	) u_issuer (
		.clk       (clk),
		.rst_n     (rst_n),
		.burst_cmd (burst_cmd),
		.cmd_index (cmd_index),
		.status    (status),
		.dram_cmd  (dram_cmd),
		.col_start (col_start)
	);

endmodule

`default_nettype wire

//--- cmd_issuer.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_issuer #(
	parameter int no_of_bursts = 4
) (
	input  wire                                              clk,
	input  wire                                              rst_n,
	input  wire mem_sched_pkg::dram_cmd_e                    burst_cmd,
	input  wire [$clog2(no_of_bursts)-1:0]                   cmd_index,
	input  wire mem_sched_pkg::slot_status_t [no_of_bursts-1:0] status,
	output mem_sched_pkg::dram_cmd_t                         dram_cmd,
	output logic [no_of_bursts-1:0]                          col_start
);
	import mem_sched_pkg::*;

	dram_cmd_e  cmd_q;  // opcode on the port
	dram_addr_t addr_q; // address of the chosen slot
	logic       is_col; // read or write

	assign is_col = (burst_cmd == read_cmd) || (burst_cmd == write_cmd);

	always_ff @(posedge clk) begin
		if (rst_n) begin
			cmd_q     <= none;
			col_start <= '0;
		end else begin
			cmd_q     <= burst_cmd;
			col_start <= is_col ? (no_of_bursts'(1) << cmd_index) : '0; // slot starts its burst
		end
	end

	always_ff @(posedge clk) begin
		addr_q <= status[cmd_index].addr; // slot address stable while pending
	end

	assign dram_cmd = '{cmd: cmd_q, addr: addr_q};

endmodule

`default_nettype wire

//--- timing_controller.sv
`timescale 1ns/1ps
`default_nettype none

module timing_controller #(
	parameter int no_of_bursts = 4
) (
	input  wire                                              clk,
	input  wire                                              rst_n,
	input  wire mem_sched_pkg::slot_status_t [no_of_bursts-1:0] status,
	output mem_sched_pkg::dram_cmd_e                         burst_cmd,
	output logic [$clog2(no_of_bursts)-1:0]                  cmd_index
);
	import mem_sched_pkg::*;

	localparam int idx_w     = $clog2(no_of_bursts);
	localparam int bank_w    = $clog2(banks_no);
	localparam int col_gap   = burst_time + col_to_col;                          // same direction
	localparam int rd_wr_gap = rd_to_data + burst_time + rd_to_wr - wr_to_data; // read then write
	localparam int wr_rd_gap = wr_to_data + burst_time + wr_to_rd - rd_to_data; // write then read
	localparam int rd_sat    = (rd_wr_gap > col_gap) ? rd_wr_gap : col_gap;
	localparam int wr_sat    = (wr_rd_gap > col_gap) ? wr_rd_gap : col_gap;

	logic [row_addr_len-1:0] open_row [banks_no]; // row per bank
	logic [banks_no-1:0]     row_open;            // row valid per bank

	// saturating counters, cycles since the command
	logic [banks_no-1:0][$clog2(act_to_act_same_bank)-1:0] cnt_act;
	logic [banks_no-1:0][$clog2(rd_to_pre)-1:0]            cnt_rd;
	logic [banks_no-1:0][$clog2(wr_to_pre)-1:0]            cnt_wr;
	logic [banks_no-1:0][$clog2(pre_to_act)-1:0]           cnt_pre;
	logic [bank_group_no-1:0][$clog2(act_to_act_diff_bank)-1:0] cnt_bg_act;
	logic [$clog2(rd_sat)-1:0] cnt_bus_rd; // since last read on the bus
	logic [$clog2(wr_sat)-1:0] cnt_bus_wr; // since last write on the bus

	logic [no_of_bursts-1:0][bank_w-1:0] bank_id;
	dram_cmd_e [no_of_bursts-1:0]        need_cmd;
	logic [no_of_bursts-1:0]             legal;
	logic [banks_no-1:0]                 hit_pending; // a slot still wants the open row
	logic [banks_no-1:0]                 bank_sel;
	logic                                act_ok;
	logic                                rd_ok;
	logic                                wr_ok;
	logic [idx_w-1:0]                    start_index; // round robin origin
	dram_cmd_e                           sel_cmd;
	logic [idx_w-1:0]                    sel_index;
	logic [bank_w-1:0]                   sel_bank;

	always_comb begin
		act_ok = 1'b1;
		for (int g = 0; g < bank_group_no; g++) begin
			if (cnt_bg_act[g] < act_to_act_diff_bank - 1) begin
				act_ok = 1'b0; // trrd holds across groups too
			end
		end
		rd_ok = (cnt_bus_rd >= col_gap - 1) && (cnt_bus_wr >= wr_rd_gap - 1);
		wr_ok = (cnt_bus_wr >= col_gap - 1) && (cnt_bus_rd >= rd_wr_gap - 1);
	end

	always_comb begin
		hit_pending = '0;
		for (int i = 0; i < no_of_bursts; i++) begin
			bank_id[i] = {status[i].addr.bg, status[i].addr.bank};
			if (status[i].state != empty && status[i].state != returning_data &&
			    row_open[bank_id[i]] && open_row[bank_id[i]] == status[i].addr.row) begin
				hit_pending[bank_id[i]] = 1'b1;
			end
		end
		for (int i = 0; i < no_of_bursts; i++) begin
			need_cmd[i] = none;
			legal[i]    = 1'b0;
			if (status[i].state != empty && status[i].state != returning_data) begin
				if (!row_open[bank_id[i]]) begin // closed bank
					need_cmd[i] = activate;
					legal[i]    = act_ok && cnt_pre[bank_id[i]] >= pre_to_act - 1 &&
					              cnt_act[bank_id[i]] >= act_to_act_same_bank - 1;
				end else if (open_row[bank_id[i]] != status[i].addr.row) begin // row miss
					need_cmd[i] = precharge;
					legal[i]    = !hit_pending[bank_id[i]] &&
					              cnt_act[bank_id[i]] >= act_to_pre - 1 &&
					              cnt_rd[bank_id[i]] >= rd_to_pre - 1 &&
					              cnt_wr[bank_id[i]] >= wr_to_pre - 1;
				end else if (status[i].rtype == read) begin
					need_cmd[i] = read_cmd;
					legal[i]    = rd_ok && cnt_act[bank_id[i]] >= act_to_col - 1 &&
					              (status[i].state == almost_done || status[i].state == full);
				end else begin
					need_cmd[i] = write_cmd;
					legal[i]    = wr_ok && cnt_act[bank_id[i]] >= act_to_col - 1 &&
					              status[i].state == full; // all beats in
				end
			end
		end
	end

	always_comb begin
		logic [idx_w-1:0] idx;
		sel_cmd   = none;
		sel_index = '0;
		idx       = '0;
		for (int k = no_of_bursts - 1; k >= 0; k--) begin // nearest to origin wins
			idx = start_index + idx_w'(k);
			if (legal[idx]) begin
				sel_cmd   = need_cmd[idx];
				sel_index = idx;
			end
		end
		sel_bank = bank_id[sel_index];
		for (int b = 0; b < banks_no; b++) begin
			bank_sel[b] = (sel_cmd != none) && (sel_bank == b);
		end
	end

	always_ff @(posedge clk) begin
		if (sel_cmd == activate) begin
			open_row[sel_bank] <= status[sel_index].addr.row;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			row_open    <= '0;
			cnt_act     <= '0;
			cnt_rd      <= '0;
			cnt_wr      <= '0;
			cnt_pre     <= '0;
			cnt_bg_act  <= '0;
			cnt_bus_rd  <= '0;
			cnt_bus_wr  <= '0;
			start_index <= '0;
			burst_cmd   <= none;
			cmd_index   <= '0;
		end else begin
			for (int b = 0; b < banks_no; b++) begin
				if (bank_sel[b] && sel_cmd == activate) begin
					cnt_act[b]  <= '0;
					row_open[b] <= 1'b1;
				end else if (cnt_act[b] != act_to_act_same_bank - 1) begin
					cnt_act[b] <= cnt_act[b] + 1'b1;
				end
				if (bank_sel[b] && sel_cmd == read_cmd) begin
					cnt_rd[b] <= '0;
				end else if (cnt_rd[b] != rd_to_pre - 1) begin
					cnt_rd[b] <= cnt_rd[b] + 1'b1;
				end
				if (bank_sel[b] && sel_cmd == write_cmd) begin
					cnt_wr[b] <= '0;
				end else if (cnt_wr[b] != wr_to_pre - 1) begin
					cnt_wr[b] <= cnt_wr[b] + 1'b1;
				end
				if (bank_sel[b] && sel_cmd == precharge) begin
					cnt_pre[b]  <= '0;
					row_open[b] <= 1'b0; // bank closed
				end else if (cnt_pre[b] != pre_to_act - 1) begin
					cnt_pre[b] <= cnt_pre[b] + 1'b1;
				end
			end
			for (int g = 0; g < bank_group_no; g++) begin
				if (sel_cmd == activate && status[sel_index].addr.bg == g) begin
					cnt_bg_act[g] <= '0;
				end else if (cnt_bg_act[g] != act_to_act_diff_bank - 1) begin
					cnt_bg_act[g] <= cnt_bg_act[g] + 1'b1;
				end
			end
			if (sel_cmd == read_cmd) begin
				cnt_bus_rd <= '0;
			end else if (cnt_bus_rd != rd_sat - 1) begin
				cnt_bus_rd <= cnt_bus_rd + 1'b1;
			end
			if (sel_cmd == write_cmd) begin
				cnt_bus_wr <= '0;
			end else if (cnt_bus_wr != wr_sat - 1) begin
				cnt_bus_wr <= cnt_bus_wr + 1'b1;
			end
			if (sel_cmd != none) begin
				start_index <= sel_index + 1'b1; // next search starts past winner
			end
			burst_cmd <= sel_cmd;
			cmd_index <= sel_index;
		end
	end

endmodule

`default_nettype wire

//--- burst_slot.sv
`timescale 1ns/1ps
`default_nettype none

module burst_slot #(
	parameter int burst_beats = 8
) (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire                            load,
	input  wire mem_sched_pkg::burst_req_t load_req,
	input  wire                            beat,
	input  wire                            col_start,
	output mem_sched_pkg::slot_status_t    status
);
	import mem_sched_pkg::*;

	burst_state_e                    state;
	burst_req_t                      req_q;    // held request
	logic [$clog2(burst_beats)-1:0]  beat_cnt; // write beats so far
	logic [$clog2(burst_time)-1:0]   ret_cnt;  // cycles in returning_data

	always_ff @(posedge clk) begin
		if (load) begin
			req_q <= load_req;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			state    <= empty;
			beat_cnt <= '0;
			ret_cnt  <= '0;
		end else begin
			case (state)
				empty: begin
					if (load) begin
						beat_cnt <= '0;
						if (load_req.rtype == read) begin
							state <= full; // nothing to fill
						end else begin
							state <= started_filling;
						end
					end
				end
				started_filling: begin
					if (beat) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (beat_cnt == burst_beats - 2) begin
							state <= almost_done;
						end
					end
				end
				almost_done: begin
					if (col_start) begin // early read start
						ret_cnt <= '0;
						state   <= returning_data;
					end else if (beat) begin
						state <= full; // last beat in
					end
				end
				full: begin
					if (col_start) begin
						ret_cnt <= '0;
						state   <= returning_data;
					end
				end
				returning_data: begin
					if (ret_cnt == burst_time - 1) begin
						state <= empty; // burst over, slot free
					end else begin
						ret_cnt <= ret_cnt + 1'b1;
					end
				end
				default: state <= empty;
			endcase
		end
	end

	assign status = '{state: state, rtype: req_q.rtype, addr: req_q.addr};

endmodule

`default_nettype wire

//--- burst_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module burst_dispatcher #(
	parameter int no_of_bursts = 4
) (
	input  wire                                             clk,
	input  wire                                             rst_n,
	input  wire                                             req_valid,
	input  wire mem_sched_pkg::burst_req_t                  req,
	input  wire                                             wr_beat,
	input  wire mem_sched_pkg::burst_state_e [no_of_bursts-1:0] slot_state,
	output logic [no_of_bursts-1:0]                         load,
	output mem_sched_pkg::burst_req_t                       load_req,
	output logic [no_of_bursts-1:0]                         beat,
	output logic                                            busy
);
	import mem_sched_pkg::*;

	logic [$clog2(no_of_bursts)-1:0] free_idx; // lowest empty slot
	logic [$clog2(no_of_bursts)-1:0] wr_idx;   // slot taking write beats
	logic                            any_free;
	logic                            accept;

	always_comb begin
		free_idx = '0;
		any_free = 1'b0;
		for (int i = no_of_bursts - 1; i >= 0; i--) begin // last hit wins, so lowest
			if (slot_state[i] == empty) begin
				free_idx = $clog2(no_of_bursts)'(i);
				any_free = 1'b1;
			end
		end
	end

	assign accept   = req_valid && any_free; // dropped when busy
	assign busy     = !any_free;
	assign load     = accept ? (no_of_bursts'(1) << free_idx) : '0;
	assign load_req = req;
	assign beat     = wr_beat ? (no_of_bursts'(1) << wr_idx) : '0;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			wr_idx <= '0;
		end else if (accept && req.rtype == write) begin
			wr_idx <= free_idx; // beats follow the newest write
		end
	end

endmodule

`default_nettype wire

//--- mem_sched_pkg.sv
`default_nettype none

package mem_sched_pkg;

	// dram geometry
	localparam int banks_no      = 16; // bg x bank
	localparam int bank_group_no = 4;
	localparam int row_addr_len  = 16;

	// same bank timing, in cycles
	localparam int act_to_col           = 6;  // trcd
	localparam int pre_to_act           = 6;  // trp
	localparam int act_to_act_same_bank = 20; // trc
	localparam int act_to_pre           = 14; // tras
	localparam int wr_to_data           = 5;  // write latency
	localparam int rd_to_data           = 7;  // read latency
	localparam int rd_to_pre            = 3;  // trtp
	localparam int wr_to_pre            = 6;

	// across banks and the shared bus
	localparam int act_to_act_diff_bank = 3;  // trrd
	localparam int rd_to_wr             = 5;  // bus turnaround
	localparam int wr_to_rd             = 9;
	localparam int col_to_col           = 2;  // gap between bursts
	localparam int burst_time           = 8;  // data beats on the bus

	typedef enum logic [2:0] {
		empty,
		started_filling,
		almost_done,     // one beat left
		full,
		returning_data
	} burst_state_e;

	typedef enum logic {
		read,
		write
	} req_type_e;

	typedef enum logic [2:0] {
		none,
		activate,
		read_cmd,
		write_cmd,
		precharge
	} dram_cmd_e;

	typedef struct packed {
		logic [1:0]              bg;
		logic [1:0]              bank;
		logic [row_addr_len-1:0] row;
	} dram_addr_t; // 20 bits

	typedef struct packed {
		req_type_e  rtype;
		dram_addr_t addr;
	} burst_req_t; // host request

	typedef struct packed {
		burst_state_e state;
		req_type_e    rtype;
		dram_addr_t   addr;
	} slot_status_t; // one per slot

	typedef struct packed {
		dram_cmd_e  cmd;
		dram_addr_t addr;
	} dram_cmd_t; // command port

endpackage

`default_nettype wire
